//--- include/vsa_defs.svh
`ifndef VSA_DEFS_SVH
`define VSA_DEFS_SVH

// datapath widths
`define VSA_DATA_W      5   // data word and register width
`define VSA_INSTR_W     12  // instruction word
`define VSA_PC_W        5   // program counter width

// instruction field widths
`define VSA_OP_W        3   // opcode field
`define VSA_FUNC_W      3   // R-format function field
`define VSA_REG_IDX_W   2   // register index field
`define VSA_IMM_W       5   // I-format immediate, overlaps dst and func

// fixed constants
`define VSA_PC_STEP     2   // pc increment per instruction
`define VSA_NUM_REGS    4   // R0 included, R0 reads zero
`define VSA_PHASE_W     3   // five phases need 3 bits

`endif

//--- hw/vsaPkg.sv
`include "vsa_defs.svh"

package vsaPkg;

    // the five phases, one clock each
    typedef enum logic [`VSA_PHASE_W-1:0] {
        IF  = 3'd0, // fetch
        ID  = 3'd1, // decode, operand read
        EX  = 3'd2, // alu / address / branch target
        MEM = 3'd3, // data port access, pc update
        WB  = 3'd4  // register write-back
    } phaseT;

    typedef enum logic [`VSA_OP_W-1:0] {
        LW    = 3'd0,
        SW    = 3'd1,
        BEQZ  = 3'd2,
        ALUOP = 3'd3, // R-format, func selects operation
        ADDI  = 3'd4,
        SUBI  = 3'd5
    } opcodeT;

    typedef enum logic [`VSA_FUNC_W-1:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        NOT = 3'd5, // inverts A only
        SRL = 3'd6,
        SRA = 3'd7
    } funcT;

    // R-format layout, I-format imm is {dst, func}
    typedef struct packed {
        opcodeT                     opcode; // [11:9]
        logic [`VSA_REG_IDX_W-1:0]  src1;   // [8:7]
        logic [`VSA_REG_IDX_W-1:0]  src2;   // [6:5]
        logic [`VSA_REG_IDX_W-1:0]  dst;    // [4:3]
        funcT                       func;   // [2:0]
    } instrFields;

    typedef struct packed {
        opcodeT                     opcode;
        funcT                       func;
        logic                       memRef;    // LW or SW
        logic                       regRegAlu; // R-format
        logic                       regImmAlu; // ADDI / SUBI
        logic                       branch;    // BEQZ
        logic                       isLoad;
        logic                       isStore;
        logic [`VSA_REG_IDX_W-1:0]  destReg;   // dst or src2 by format
        logic                       regWrite;  // never set for R0
        logic [`VSA_IMM_W-1:0]      imm;
    } ctrlBundle;

    typedef struct packed {
        logic [`VSA_DATA_W-1:0] a; // latched src1
        logic [`VSA_DATA_W-1:0] b; // latched src2, also store data
    } operandBundle;

    typedef struct packed {
        logic [`VSA_DATA_W-1:0] aluOut; // result, address or target
        logic                   cond;   // branch taken
    } execBundle;

endpackage

//--- hw/vsaSequencer.sv
`timescale 1ns/1ns
`include "vsa_defs.svh"

module vsaSequencer (
    input  logic                     clock,
    input  logic                     rstN,
    input  logic [`VSA_INSTR_W-1:0]  instruction, // from instruction port
    input  logic                     pcLoad,      // MEM-cycle strobe from result
    input  logic [`VSA_PC_W-1:0]     pcNext,
    output vsaPkg::phaseT            phase,
    output vsaPkg::instrFields       ir,
    output logic [`VSA_PC_W-1:0]     pc,
    output logic [`VSA_PC_W-1:0]     npc
);

    vsaPkg::phaseT phaseNext;

    // fixed five-step cycle, no stalls
    always_comb begin
        case (phase)
            vsaPkg::IF:  phaseNext = vsaPkg::ID;
            vsaPkg::ID:  phaseNext = vsaPkg::EX;
            vsaPkg::EX:  phaseNext = vsaPkg::MEM;
            vsaPkg::MEM: phaseNext = vsaPkg::WB;
            default:     phaseNext = vsaPkg::IF; // WB wraps
        endcase
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            phase <= vsaPkg::IF;
        end else begin
            phase <= phaseNext;
        end
    end

    // fetch: capture instruction, precompute fall-through pc
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            ir  <= '0;
            npc <= '0;
        end else if (phase == vsaPkg::IF) begin
            ir  <= vsaPkg::instrFields'(instruction);
            npc <= pc + `VSA_PC_W'(`VSA_PC_STEP); // wraps mod 32
        end
    end

    // architectural pc, only moves at end of MEM
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (pcLoad) begin
            pc <= pcNext;
        end
    end

    // phase must stay within IF..WB
    assert property (@(posedge clock) disable iff (!rstN)
        phase inside {vsaPkg::IF, vsaPkg::ID, vsaPkg::EX, vsaPkg::MEM, vsaPkg::WB})
        else $error("phase left the five-step cycle");

endmodule

//--- hw/vsaDecode.sv
`timescale 1ns/1ns
`include "vsa_defs.svh"

module vsaDecode (
    input  logic                       clock,
    input  logic                       rstN,
    input  vsaPkg::phaseT              phase,
    input  vsaPkg::instrFields         ir,
    input  logic [`VSA_DATA_W-1:0]     rdData1, // regfile read port 1
    input  logic [`VSA_DATA_W-1:0]     rdData2, // regfile read port 2
    output logic [`VSA_REG_IDX_W-1:0]  rdAddr1,
    output logic [`VSA_REG_IDX_W-1:0]  rdAddr2,
    output vsaPkg::ctrlBundle          ctrl,
    output vsaPkg::operandBundle       ops
);

    logic writesReg; // class has a register result

    // both formats read src1, src2 is either operand B or I-format dest
    assign rdAddr1 = ir.src1;
    assign rdAddr2 = ir.src2;

    always_comb begin
        ctrl = '0;
        ctrl.opcode = ir.opcode;
        ctrl.func   = ir.func;
        ctrl.imm    = {ir.dst, ir.func}; // low 5 bits of ir

        // instruction classes
        ctrl.isLoad    = (ir.opcode == vsaPkg::LW);
        ctrl.isStore   = (ir.opcode == vsaPkg::SW);
        ctrl.memRef    = ctrl.isLoad || ctrl.isStore;
        ctrl.regRegAlu = (ir.opcode == vsaPkg::ALUOP);
        ctrl.regImmAlu = (ir.opcode == vsaPkg::ADDI) || (ir.opcode == vsaPkg::SUBI);
        ctrl.branch    = (ir.opcode == vsaPkg::BEQZ);

        // R-format writes dst, I-format writes src2 field
        if (ctrl.regRegAlu) begin
            ctrl.destReg = ir.dst;
        end else begin
            ctrl.destReg = ir.src2;
        end

        writesReg = ctrl.regRegAlu || ctrl.regImmAlu || ctrl.isLoad;
        ctrl.regWrite = writesReg && (ctrl.destReg != '0); // R0 stays zero
    end

    // operand latch, end of ID
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            ops <= '0;
        end else if (phase == vsaPkg::ID) begin
            ops.a <= rdData1;
            ops.b <= rdData2;
        end
    end

endmodule

//--- hw/vsaExecute.sv
`timescale 1ns/1ns
`include "vsa_defs.svh"

module vsaExecute (
    input  logic                    clock,
    input  logic                    rstN,
    input  vsaPkg::phaseT           phase,
    input  vsaPkg::ctrlBundle       ctrl,
    input  vsaPkg::operandBundle    ops,
    input  logic [`VSA_PC_W-1:0]    npc,
    output vsaPkg::execBundle       ex
);

    logic [`VSA_DATA_W-1:0] aluNext;   // value for aluOut at end of EX
    logic [`VSA_DATA_W-1:0] rAluRes;   // R-format result
    logic [`VSA_PC_W-1:0]   brTarget;  // npc + 2*imm[3:0]

    // R-format group, everything wraps mod 32
    always_comb begin
        case (ctrl.func)
            vsaPkg::ADD: rAluRes = ops.a + ops.b;
            vsaPkg::SUB: rAluRes = ops.a - ops.b;
            vsaPkg::AND: rAluRes = ops.a & ops.b;
            vsaPkg::OR:  rAluRes = ops.a | ops.b;
            vsaPkg::XOR: rAluRes = ops.a ^ ops.b;
            vsaPkg::NOT: rAluRes = ~ops.a;           // B ignored
            vsaPkg::SRL: rAluRes = {1'b0, ops.a[`VSA_DATA_W-1:1]};
            default:     rAluRes = {ops.a[`VSA_DATA_W-1], ops.a[`VSA_DATA_W-1:1]}; // SRA
        endcase
    end

    // only 4 imm bits, doubled; no sign extension
    assign brTarget = npc + {ctrl.imm[3:0], 1'b0};

    always_comb begin
        aluNext = ex.aluOut; // hold for unknown opcodes
        if (ctrl.memRef) begin
            aluNext = ops.a + ctrl.imm; // data address
        end else if (ctrl.regRegAlu) begin
            aluNext = rAluRes;
        end else if (ctrl.regImmAlu) begin
            if (ctrl.opcode == vsaPkg::ADDI) begin
                aluNext = ops.a + ctrl.imm;
            end else begin
                aluNext = ops.a - ctrl.imm; // SUBI
            end
        end else if (ctrl.branch) begin
            aluNext = brTarget;
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            ex <= '0;
        end else if (phase == vsaPkg::EX) begin
            ex.aluOut <= aluNext;
            if (ctrl.branch) begin
                ex.cond <= (ops.a == '0); // BEQZ test on src1
            end
        end
    end

endmodule

//--- hw/vsaResult.sv
`timescale 1ns/1ns
`include "vsa_defs.svh"

module vsaResult (
    input  logic                       clock,
    input  logic                       rstN,
    input  vsaPkg::phaseT              phase,
    input  vsaPkg::ctrlBundle          ctrl,
    input  vsaPkg::operandBundle       ops,
    input  vsaPkg::execBundle          ex,
    input  logic [`VSA_PC_W-1:0]       npc,
    input  logic [`VSA_DATA_W-1:0]     dataIn,  // data port read
    input  logic [`VSA_REG_IDX_W-1:0]  rdAddr1,
    input  logic [`VSA_REG_IDX_W-1:0]  rdAddr2,
    output logic [`VSA_DATA_W-1:0]     rdData1,
    output logic [`VSA_DATA_W-1:0]     rdData2,
    output logic [`VSA_DATA_W-1:0]     dataAddr,
    output logic [`VSA_DATA_W-1:0]     dataOut,
    output logic                       wr,
    output logic                       pcLoad,
    output logic [`VSA_PC_W-1:0]       pcNext
);

    logic [`VSA_DATA_W-1:0] regFile [`VSA_NUM_REGS]; // R0 slot never written
    logic [`VSA_DATA_W-1:0] lmd;     // load memory data
    logic [`VSA_DATA_W-1:0] wbData;  // value going to destReg
    logic                   regWe;

    // combinational read ports for decode
    assign rdData1 = (rdAddr1 == '0) ? '0 : regFile[rdAddr1];
    assign rdData2 = (rdAddr2 == '0) ? '0 : regFile[rdAddr2];

    // data port
    assign dataAddr = ex.aluOut; // registered in EX, valid from MEM
    assign dataOut  = ops.b;
    assign wr       = (phase == vsaPkg::MEM) && ctrl.isStore;

    // pc update once per instruction, end of MEM
    assign pcLoad = (phase == vsaPkg::MEM);
    assign pcNext = (ctrl.branch && ex.cond) ? ex.aluOut : npc;

    // load data register
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            lmd <= '0;
        end else if (phase == vsaPkg::MEM && ctrl.isLoad) begin
            lmd <= dataIn;
        end
    end

    assign wbData = ctrl.isLoad ? lmd : ex.aluOut;
    assign regWe  = (phase == vsaPkg::WB) && ctrl.regWrite;

    // register file, all zero out of reset
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `VSA_NUM_REGS; i++) begin
                regFile[i] <= '0;
            end
        end else if (regWe) begin
            regFile[ctrl.destReg] <= wbData;
        end
    end

    // store strobe lasts one cycle and is followed by write-back
    assert property (@(posedge clock) disable iff (!rstN)
        wr |-> (ctrl.isStore && $past(phase) == vsaPkg::EX) ##1 (!wr && phase == vsaPkg::WB))
        else $error("write strobe outside the MEM cycle of a store");

    // decode must never hand a write to R0 down to write-back
    assert property (@(posedge clock) disable iff (!rstN)
        (phase == vsaPkg::WB && ctrl.regWrite) |-> ctrl.destReg != '0)
        else $error("register write aimed at R0");

endmodule

//--- hw/vsaCore.sv
`timescale 1ns/1ns
`include "vsa_defs.svh"

module vsaCore (
    input  logic                     clock,
    input  logic                     rstN,
    input  logic [`VSA_INSTR_W-1:0]  instruction, // instruction port data
    input  logic [`VSA_DATA_W-1:0]   dataIn,      // data port read data
    output logic [`VSA_PC_W-1:0]     pc,          // instruction port address
    output logic [`VSA_DATA_W-1:0]   dataAddr,
    output logic [`VSA_DATA_W-1:0]   dataOut,
    output logic                     wr
);

    vsaPkg::phaseT              phase;
    vsaPkg::instrFields         ir;
    vsaPkg::ctrlBundle          ctrl;
    vsaPkg::operandBundle       ops;
    vsaPkg::execBundle          ex;
    logic [`VSA_PC_W-1:0]       npc;
    logic [`VSA_PC_W-1:0]       pcNext;
    logic                       pcLoad;
    logic [`VSA_REG_IDX_W-1:0]  rdAddr1, rdAddr2; // decode to regfile
    logic [`VSA_DATA_W-1:0]     rdData1, rdData2;

    vsaSequencer uSequencer (
        .clock(clock), .rstN(rstN), .instruction(instruction),
        .pcLoad(pcLoad), .pcNext(pcNext),
        .phase(phase), .ir(ir), .pc(pc), .npc(npc)
    );

    vsaDecode uDecode (
        .clock(clock), .rstN(rstN), .phase(phase), .ir(ir),
        .rdData1(rdData1), .rdData2(rdData2),
        .rdAddr1(rdAddr1), .rdAddr2(rdAddr2), .ctrl(ctrl), .ops(ops)
    );

    vsaExecute uExecute (
        .clock(clock), .rstN(rstN), .phase(phase),
        .ctrl(ctrl), .ops(ops), .npc(npc), .ex(ex)
    );

    // regfile, data port and pc write-back
    vsaResult uResult (
        .clock(clock), .rstN(rstN), .phase(phase),
        .ctrl(ctrl), .ops(ops), .ex(ex), .npc(npc), .dataIn(dataIn),
        .rdAddr1(rdAddr1), .rdAddr2(rdAddr2),
        .rdData1(rdData1), .rdData2(rdData2),
        .dataAddr(dataAddr), .dataOut(dataOut), .wr(wr),
        .pcLoad(pcLoad), .pcNext(pcNext)
    );

endmodule

//--- tests/vsaCoreTb.sv
`timescale 1ns/1ns
`include "vsa_defs.svh"

module vsaCoreTb;

    localparam int PROG_LEN = 16;               // instructions in the ROM
    localparam int CYCLE_LIMIT = PROG_LEN * 5 + 40;
    localparam logic [`VSA_PC_W-1:0] LOOP_PC = 5'd30; // self branch

    logic clock;
    logic rstN;
    logic [`VSA_INSTR_W-1:0] instruction;
    logic [`VSA_DATA_W-1:0] dataIn;
    logic [`VSA_PC_W-1:0] pc;
    logic [`VSA_DATA_W-1:0] dataAddr;
    logic [`VSA_DATA_W-1:0] dataOut;
    logic wr;

    logic [`VSA_INSTR_W-1:0] rom [32];
    logic [`VSA_DATA_W-1:0] ram [32];
    integer seed;
    int errors;

    // shadow architecture state
    logic [2:0] phaseCnt;                       // 0 = IF .. 4 = WB
    logic [`VSA_DATA_W-1:0] shadowRegs [`VSA_NUM_REGS];
    logic [`VSA_PC_W-1:0] shadowPc;
    logic [`VSA_PC_W-1:0] fetchPc;              // pc of instruction in flight
    logic curStore;
    logic curMemRef;
    logic [`VSA_DATA_W-1:0] expAddr;
    logic [`VSA_DATA_W-1:0] expData;
    int loopFetches;

    vsaCore DUT (
        .clock(clock), .rstN(rstN), .instruction(instruction), .dataIn(dataIn),
        .pc(pc), .dataAddr(dataAddr), .dataOut(dataOut), .wr(wr)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic logic [`VSA_INSTR_W-1:0] encodeR(input vsaPkg::funcT f,
            input logic [1:0] s1, input logic [1:0] s2, input logic [1:0] d);
        return {vsaPkg::ALUOP, s1, s2, d, f};
    endfunction

    function automatic logic [`VSA_INSTR_W-1:0] encodeI(input vsaPkg::opcodeT op,
            input logic [1:0] s1, input logic [1:0] s2, input logic [4:0] imm);
        return {op, s1, s2, imm};
    endfunction

    task automatic loadProgram();
        for (int i = 0; i < 32; i++) begin
            rom[i] = '0; // odd slots never fetched
        end
        rom[0]  = encodeI(vsaPkg::LW, 2'd0, 2'd1, 5'd5);    // R1 = ram[5]
        rom[2]  = encodeI(vsaPkg::SW, 2'd1, 2'd1, 5'd0);    // loaded word back out
        rom[4]  = encodeI(vsaPkg::ADDI, 2'd1, 2'd2, 5'd13);
        rom[6]  = encodeI(vsaPkg::SUBI, 2'd1, 2'd3, 5'd6);
        rom[8]  = encodeR(vsaPkg::ADD, 2'd2, 2'd3, 2'd1);
        rom[10] = encodeR(vsaPkg::SUB, 2'd3, 2'd1, 2'd2);
        rom[12] = encodeR(vsaPkg::AND, 2'd1, 2'd2, 2'd3);
        rom[14] = encodeR(vsaPkg::XOR, 2'd2, 2'd3, 2'd2);
        rom[16] = encodeR(vsaPkg::NOT, 2'd2, 2'd0, 2'd3);
        rom[18] = encodeR(vsaPkg::OR, 2'd2, 2'd3, 2'd1);    // x | ~x, never zero
        rom[20] = encodeR(vsaPkg::SRA, 2'd3, 2'd0, 2'd2);
        rom[22] = encodeR(vsaPkg::SRL, 2'd2, 2'd0, 2'd3);
        rom[24] = encodeR(vsaPkg::ADD, 2'd2, 2'd3, 2'd0);   // aimed at R0, lost
        rom[26] = encodeI(vsaPkg::BEQZ, 2'd1, 2'd0, 5'd3);  // not taken
        rom[28] = encodeI(vsaPkg::SW, 2'd3, 2'd0, 5'd0);    // stores R0
        rom[30] = encodeI(vsaPkg::BEQZ, 2'd0, 2'd0, 5'd15); // branch to itself
    endtask

    // memories answer a short delay after each edge
    always @(posedge clock) begin
        #2;
        instruction = rom[pc];
        dataIn = ram[dataAddr];
    end

    always @(posedge clock) begin
        if (wr) begin
            ram[dataAddr] <= dataOut;
        end
    end

    always @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            phaseCnt <= 3'd0;
        end else begin
            phaseCnt <= (phaseCnt == 3'd4) ? 3'd0 : phaseCnt + 3'd1;
        end
    end

    // executes the whole instruction at the end of its fetch cycle
    always @(posedge clock or negedge rstN) begin : shadowModel
        logic [`VSA_INSTR_W-1:0] instr;
        logic [2:0] op;
        logic [1:0] s1, s2, d;
        logic [2:0] f;
        logic [4:0] imm;
        logic [`VSA_DATA_W-1:0] a, b, res;
        logic [`VSA_PC_W-1:0] nextPc;
        logic [1:0] dest;
        logic writes;
        if (!rstN) begin
            for (int i = 0; i < `VSA_NUM_REGS; i++) begin
                shadowRegs[i] <= '0;
            end
            shadowPc <= '0;
            fetchPc <= '0;
            curStore <= 1'b0;
            curMemRef <= 1'b0;
            expAddr <= '0;
            expData <= '0;
            loopFetches <= 0;
        end else if (phaseCnt == 3'd0) begin
            instr = rom[shadowPc];
            op = instr[11:9];
            s1 = instr[8:7];
            s2 = instr[6:5];
            d = instr[4:3];
            f = instr[2:0];
            imm = instr[4:0];
            a = shadowRegs[s1];
            b = shadowRegs[s2];
            nextPc = shadowPc + 5'd2;           // wraps mod 32
            res = '0;
            dest = s2;                          // I-format target
            writes = 1'b0;
            case (op)
                3'd0: begin                     // LW
                    res = ram[a + imm];
                    writes = 1'b1;
                end
                3'd2: begin                     // BEQZ
                    if (a == '0) begin
                        nextPc = shadowPc + 5'd2 + {imm[3:0], 1'b0};
                    end
                end
                3'd3: begin
                    dest = d;
                    writes = 1'b1;
                    case (f)
                        3'd0: res = a + b;
                        3'd1: res = a - b;
                        3'd2: res = a & b;
                        3'd3: res = a | b;
                        3'd4: res = a ^ b;
                        3'd5: res = ~a;
                        3'd6: res = a >> 1;
                        default: res = 5'($signed(a) >>> 1);
                    endcase
                end
                3'd4: begin                     // ADDI
                    res = a + imm;
                    writes = 1'b1;
                end
                3'd5: begin                     // SUBI
                    res = a - imm;
                    writes = 1'b1;
                end
                default: ;                      // SW changes no register
            endcase
            if (writes && dest != 2'd0) begin
                shadowRegs[dest] <= res;
            end
            curStore <= (op == 3'd1);
            curMemRef <= (op == 3'd0) || (op == 3'd1);
            expAddr <= a + imm;
            expData <= b;
            fetchPc <= shadowPc;
            shadowPc <= nextPc;
            if (shadowPc == LOOP_PC) begin
                loopFetches <= loopFetches + 1;
            end
        end
    end

    assert property (@(posedge clock) disable iff (!rstN)
        phaseCnt == 3'd0 |-> pc == shadowPc)
        else begin
            errors++;
            $display("MISMATCH pc at fetch expected %h actual %h",
                $sampled(shadowPc), $sampled(pc));
        end

    assert property (@(posedge clock) disable iff (!rstN)
        (phaseCnt >= 3'd1 && phaseCnt <= 3'd3) |-> pc == fetchPc)
        else begin
            errors++;
            $display("MISMATCH pc held expected %h actual %h",
                $sampled(fetchPc), $sampled(pc));
        end

    // by WB the branch or fall-through pc is in place
    assert property (@(posedge clock) disable iff (!rstN)
        phaseCnt == 3'd4 |-> pc == shadowPc)
        else begin
            errors++;
            $display("MISMATCH pc after update expected %h actual %h",
                $sampled(shadowPc), $sampled(pc));
        end

    assert property (@(posedge clock) disable iff (!rstN)
        (phaseCnt == 3'd3 && curStore) |-> wr)
        else begin
            errors++;
            $display("store at pc %h did not raise the write strobe", $sampled(fetchPc));
        end

    assert property (@(posedge clock) disable iff (!rstN)
        !(phaseCnt == 3'd3 && curStore) |-> !wr)
        else begin
            errors++;
            $display("write strobe high outside a store's memory cycle");
        end

    assert property (@(posedge clock) disable iff (!rstN)
        (phaseCnt == 3'd3 && curMemRef) |-> dataAddr == expAddr)
        else begin
            errors++;
            $display("MISMATCH dataAddr expected %h actual %h",
                $sampled(expAddr), $sampled(dataAddr));
        end

    assert property (@(posedge clock) disable iff (!rstN)
        (phaseCnt == 3'd3 && curStore) |-> dataOut == expData)
        else begin
            errors++;
            $display("MISMATCH dataOut expected %h actual %h",
                $sampled(expData), $sampled(dataOut));
        end

    initial begin
        int cycles;
        logic timedOut;
        rstN = 1'b0;
        instruction = '0;
        dataIn = '0;
        errors = 0;
        cycles = 0;
        timedOut = 1'b0;
        seed = 44;
        loadProgram();
        for (int i = 0; i < 32; i++) begin
            ram[i] = 5'($random(seed));
        end
        repeat (2) @(posedge clock);
        #2 rstN = 1'b1;
        // program is done once the final loop has been fetched twice
        while (loopFetches < 2 && !timedOut) begin
            @(posedge clock);
            cycles++;
            if (cycles >= CYCLE_LIMIT) begin
                timedOut = 1'b1;
            end
        end
        if (timedOut) begin
            $display("timeout after %0d cycles, program never reached its final loop", cycles);
        end
        repeat (5) @(posedge clock);            // let the last checks fire
        $display("run finished after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0 && !timedOut) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- vsaCore.f
+incdir+include
hw/vsaPkg.sv
hw/vsaSequencer.sv
hw/vsaDecode.sv
hw/vsaExecute.sv
hw/vsaResult.sv
hw/vsaCore.sv
tests/vsaCoreTb.sv

//--- Makefile
# Verilator simulation of the vsaCore processor
VERILATOR ?= verilator
TOP       ?= vsaCoreTb
FILELIST  ?= vsaCore.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
